//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_weight_path
FILELIST := build.f
OBJ_DIR  := obj_dir

SOURCES  := $(wildcard logic/*.sv logic/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+logic
+incdir+testbench
logic/gcn_pkg.sv
logic/weight_sram.sv
logic/weight_cntl.sv
logic/vertex_mac.sv
logic/gcn_weight_path.sv
testbench/tb_weight_path.sv

//--- logic/gcn_config.svh
`ifndef GCN_CONFIG_SVH
`define GCN_CONFIG_SVH

// feature vector and layer limits
`define MAX_FV_NUM        16
`define MAX_WEIGHT_LAYER  4

// one weight and one feature are the same width
`define FV_SIZE           8
`define MULT_PER_PE       2

// weight sram geometry, address is {layer, line}
`define WEIGHT_SRAM_BW    16
`define WEIGHT_SRAM_AW    5

// accumulator wide enough for MAX_FV_NUM full-scale products
`define ACC_W             20

// derived field widths
`define FV_IDX_W          ($clog2(`MAX_FV_NUM))
`define FV_NUM_W          ($clog2(`MAX_FV_NUM) + 1)
`define LAYER_W           ($clog2(`MAX_WEIGHT_LAYER))
`define LINE_W            ($clog2(`MAX_FV_NUM / `MULT_PER_PE))

`endif

//--- logic/gcn_pkg.sv
`default_nettype none

`include "gcn_config.svh"

package gcn_pkg;

    // two weights, element 0 in the low byte
    typedef logic [`MULT_PER_PE-1:0][`FV_SIZE-1:0] weight_pair_t;

    // sram read request, cen and wen active low
    typedef struct packed {
        logic                       cen;
        logic                       wen;
        logic [`WEIGHT_SRAM_AW-1:0] addr;
    } weight_sram_req_t;

    // raw word for the loader, weight pair for the controller
    typedef union packed {
        logic [`WEIGHT_SRAM_BW-1:0] raw;
        weight_pair_t               w;
    } weight_word_u;

    // stream markers toward the bank
    typedef struct packed {
        logic sos;
        logic change;
        logic eos;
    } weight_bank_ctl_t;

    typedef struct packed {
        logic                 valid;
        weight_pair_t         weight;
        logic [`FV_IDX_W-1:0] fv_idx;
        weight_bank_ctl_t     ctl;
    } weight_beat_t;

endpackage

`default_nettype wire

//--- logic/gcn_weight_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "gcn_config.svh"

module gcn_weight_path (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       fire,
    input  wire logic [`LAYER_W-1:0]        num_weight_layer,
    input  wire logic [`FV_NUM_W-1:0]       num_fv,
    input  wire logic                       weight_load_wr,
    input  wire logic [`WEIGHT_SRAM_AW-1:0] weight_load_addr,
    input  wire logic [`WEIGHT_SRAM_BW-1:0] weight_load_data,
    input  wire logic                       feature_wr,
    input  wire logic [`FV_IDX_W-1:0]       feature_addr,
    input  wire logic [`FV_SIZE-1:0]        feature_data,
    output logic                            rs_idle,
    output gcn_pkg::weight_beat_t           beat,
    output logic                            sum_valid,
    output logic [`LAYER_W-1:0]             sum_layer,
    output logic [`ACC_W-1:0]               layer_sum,
    output logic                            done
);
    import gcn_pkg::*;

    wire weight_sram_req_t sram_req;
    wire weight_word_u     sram_q;

    weight_sram u_weight_sram (
        .clk       (clk),
        .req       (sram_req),
        .q         (sram_q),
        .load_wr   (weight_load_wr),
        .load_addr (weight_load_addr),
        .load_data (weight_load_data)
    );

    // beat goes to the mac and out to the bank side
    weight_cntl u_weight_cntl (
        .clk              (clk),
        .reset            (reset),
        .fire             (fire),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .sram_req         (sram_req),
        .sram_q           (sram_q),
        .beat             (beat),
        .rs_idle          (rs_idle)
    );

    vertex_mac u_vertex_mac (
        .clk          (clk),
        .reset        (reset),
        .feature_wr   (feature_wr),
        .feature_addr (feature_addr),
        .feature_data (feature_data),
        .beat         (beat),
        .sum_valid    (sum_valid),
        .sum_layer    (sum_layer),
        .layer_sum    (layer_sum),
        .done         (done)
    );

endmodule

`default_nettype wire

//--- logic/vertex_mac.sv
`timescale 1ns/10ps
`default_nettype none

`include "gcn_config.svh"

module vertex_mac (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  feature_wr,
    input  wire logic [`FV_IDX_W-1:0]  feature_addr,
    input  wire logic [`FV_SIZE-1:0]   feature_data,
    input  wire gcn_pkg::weight_beat_t beat,
    output logic                       sum_valid,
    output logic [`LAYER_W-1:0]        sum_layer,
    output logic [`ACC_W-1:0]          layer_sum,
    output logic                       done
);

    // this vertex's feature vector
    logic [`FV_SIZE-1:0] feature [`MAX_FV_NUM];

    logic [`ACC_W-1:0]   acc;
    logic [`ACC_W-1:0]   beat_sum;
    logic [`ACC_W-1:0]   acc_next;
    logic [`LAYER_W-1:0] layer_cnt;
    logic [`LAYER_W-1:0] cur_layer;

    always_ff @(posedge clk) begin
        if (feature_wr) begin
            feature[feature_addr] <= feature_data;
        end
    end

    // unsigned products of one beat
    always_comb begin
        logic [2*`FV_SIZE-1:0] prod;
        beat_sum = '0;
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            prod     = feature[beat.fv_idx + `FV_IDX_W'(i)] * beat.weight[i];
            beat_sum = beat_sum + `ACC_W'(prod);
        end
    end

    assign acc_next  = acc + beat_sum;

    // sos starts a fresh stream
    assign cur_layer = beat.ctl.sos ? '0 : layer_cnt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            acc       <= '0;
            layer_cnt <= '0;
            sum_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            sum_valid <= beat.valid && beat.ctl.change;
            done      <= beat.valid && beat.ctl.change && beat.ctl.eos;
            if (beat.valid) begin
                if (beat.ctl.change) begin
                    acc       <= '0;
                    layer_cnt <= cur_layer + 1'b1;
                end else begin
                    acc       <= acc_next;
                    layer_cnt <= cur_layer;
                end
            end
        end
    end

    // completed layer result
    always_ff @(posedge clk) begin
        if (beat.valid && beat.ctl.change) begin
            layer_sum <= acc_next;
            sum_layer <= cur_layer;
        end
    end

endmodule

`default_nettype wire

//--- logic/weight_cntl.sv
`timescale 1ns/10ps
`default_nettype none

`include "gcn_config.svh"

module weight_cntl (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   fire,
    input  wire logic [`LAYER_W-1:0]    num_weight_layer,
    input  wire logic [`FV_NUM_W-1:0]   num_fv,
    output gcn_pkg::weight_sram_req_t   sram_req,
    input  wire gcn_pkg::weight_word_u  sram_q,
    output gcn_pkg::weight_beat_t       beat,
    output logic                        rs_idle
);
    import gcn_pkg::*;

    typedef enum logic {
        S_IDLE = 1'b0,
        S_WORK = 1'b1
    } state_t;

    localparam logic [`FV_IDX_W-1:0] FV_STEP = `FV_IDX_W'(`MULT_PER_PE);

    state_t               state;
    logic [`LAYER_W-1:0]  layer_cnt;
    logic [`LINE_W-1:0]   line_cnt;
    logic [`FV_IDX_W-1:0] fv_cnt;

    logic issue;
    logic layer_end;
    logic last_req;

    // request stage
    logic                       req_cen;
    logic [`WEIGHT_SRAM_AW-1:0] req_addr;
    logic [`FV_IDX_W-1:0]       req_fv_idx;
    weight_bank_ctl_t           req_ctl;

    // shadow of the request metadata, lines up with sram_q
    logic                 sh_valid;
    logic [`FV_IDX_W-1:0] sh_fv_idx;
    weight_bank_ctl_t     sh_ctl;

    // beat stage
    logic                 beat_valid;
    weight_pair_t         beat_weight;
    logic [`FV_IDX_W-1:0] beat_fv_idx;
    weight_bank_ctl_t     beat_ctl;

    // fire only counts while idle is being shown
    always_comb begin
        if (state == S_IDLE) begin
            issue = fire && rs_idle;
        end else begin
            issue = 1'b1;
        end
    end

    // this request covers the last two elements of the layer
    assign layer_end = ({1'b0, fv_cnt} + {1'b0, FV_STEP}) == num_fv;
    assign last_req  = layer_end && (layer_cnt == num_weight_layer);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= S_IDLE;
            layer_cnt  <= '0;
            line_cnt   <= '0;
            fv_cnt     <= '0;
            rs_idle    <= 1'b1;
            req_cen    <= 1'b1;
            req_ctl    <= '0;
            sh_valid   <= 1'b0;
            sh_ctl     <= '0;
            beat_valid <= 1'b0;
            beat_ctl   <= '0;
        end else begin
            // high again one edge after the last request
            rs_idle <= (state == S_IDLE) && !issue;
            req_cen <= !issue;

            if (issue) begin
                req_ctl.sos    <= (state == S_IDLE);
                req_ctl.change <= layer_end;
                req_ctl.eos    <= last_req;
            end else begin
                req_ctl <= '0;
            end

            sh_valid   <= !req_cen;
            sh_ctl     <= req_ctl;
            beat_valid <= sh_valid;
            beat_ctl   <= sh_ctl;

            // layer-major, line-minor walk
            if (issue) begin
                if (layer_end) begin
                    fv_cnt    <= '0;
                    line_cnt  <= '0;
                    layer_cnt <= last_req ? '0 : layer_cnt + 1'b1;
                end else begin
                    fv_cnt   <= fv_cnt + FV_STEP;
                    line_cnt <= line_cnt + 1'b1;
                end
                state <= last_req ? S_IDLE : S_WORK;
            end
        end
    end

    // payload pipeline
    always_ff @(posedge clk) begin
        req_addr    <= {layer_cnt, line_cnt};
        req_fv_idx  <= fv_cnt;
        sh_fv_idx   <= req_fv_idx;
        beat_weight <= sram_q.w;
        beat_fv_idx <= sh_fv_idx;
    end

    // read-only port, wen held high
    assign sram_req = '{cen: req_cen, wen: 1'b1, addr: req_addr};

    assign beat = '{
        valid:  beat_valid,
        weight: beat_weight,
        fv_idx: beat_fv_idx,
        ctl:    beat_ctl
    };

endmodule

`default_nettype wire

//--- logic/weight_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "gcn_config.svh"

module weight_sram (
    input  wire logic                       clk,
    input  wire gcn_pkg::weight_sram_req_t  req,
    output gcn_pkg::weight_word_u           q,
    input  wire logic                       load_wr,
    input  wire logic [`WEIGHT_SRAM_AW-1:0] load_addr,
    input  wire logic [`WEIGHT_SRAM_BW-1:0] load_data
);

    localparam int DEPTH = 1 << `WEIGHT_SRAM_AW;

    // upper bits select the layer, lower bits the line
    logic [`WEIGHT_SRAM_BW-1:0] mem [DEPTH];

    // load port from the testbench or dma side
    always_ff @(posedge clk) begin
        if (load_wr) begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read, one cycle latency
    // q holds its last value while the port is deselected
    always_ff @(posedge clk) begin
        if (!req.cen && req.wen) begin
            q.raw <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// layers is num_weight_layer, the layer count minus one
// beats = layer count * num_fv/2, sums = layer count
typedef struct packed {
    logic [`LAYER_W-1:0]  layers;
    logic [`FV_NUM_W-1:0] num_fv;
    logic                 all_ones;
    logic                 busy_fire;
    logic [7:0]           beats;
    logic [7:0]           sums;
} case_t;

localparam int NUM_CASES = 7;

localparam case_t CASES [NUM_CASES] = '{
    '{layers: 2'd0, num_fv: 5'd2,  all_ones: 1'b0, busy_fire: 1'b0, beats: 8'd1,  sums: 8'd1},
    '{layers: 2'd1, num_fv: 5'd8,  all_ones: 1'b0, busy_fire: 1'b0, beats: 8'd8,  sums: 8'd2},
    '{layers: 2'd2, num_fv: 5'd6,  all_ones: 1'b0, busy_fire: 1'b1, beats: 8'd9,  sums: 8'd3},
    '{layers: 2'd3, num_fv: 5'd16, all_ones: 1'b0, busy_fire: 1'b1, beats: 8'd32, sums: 8'd4},
    '{layers: 2'd3, num_fv: 5'd16, all_ones: 1'b1, busy_fire: 1'b0, beats: 8'd32, sums: 8'd4},
    '{layers: 2'd0, num_fv: 5'd16, all_ones: 1'b0, busy_fire: 1'b0, beats: 8'd8,  sums: 8'd1},
    '{layers: 2'd3, num_fv: 5'd4,  all_ones: 1'b0, busy_fire: 1'b0, beats: 8'd8,  sums: 8'd4}
};

`endif

//--- testbench/tb_weight_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "gcn_config.svh"

module tb_weight_path;
    import gcn_pkg::*;

    `include "tb_cases.svh"

    localparam int LINES_PER_LAYER = `MAX_FV_NUM / `MULT_PER_PE;
    localparam int SRAM_WORDS      = 1 << `WEIGHT_SRAM_AW;
    localparam int LOAD_CYCLES     = SRAM_WORDS + `MAX_FV_NUM;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       fire;
    logic [`LAYER_W-1:0]        num_weight_layer;
    logic [`FV_NUM_W-1:0]       num_fv;
    logic                       weight_load_wr;
    logic [`WEIGHT_SRAM_AW-1:0] weight_load_addr;
    logic [`WEIGHT_SRAM_BW-1:0] weight_load_data;
    logic                       feature_wr;
    logic [`FV_IDX_W-1:0]       feature_addr;
    logic [`FV_SIZE-1:0]        feature_data;
    logic                       rs_idle;
    weight_beat_t               beat;
    logic                       sum_valid;
    logic [`LAYER_W-1:0]        sum_layer;
    logic [`ACC_W-1:0]          layer_sum;
    logic                       done;

    // copies of everything loaded into the DUT
    logic [`WEIGHT_SRAM_BW-1:0] wmem [SRAM_WORDS];
    logic [`FV_SIZE-1:0]        feat [`MAX_FV_NUM];

    int   seed = 52;
    int   exp_fv = 0;
    int   exp_beats = 0;
    int   exp_sums = 0;
    int   beat_cnt = 0;
    int   sum_cnt = 0;
    logic done_seen = 1'b0;
    int   cycle_cnt = 0;
    int   timeout_limit;

    gcn_weight_path dut_i (
        .clk              (clk),
        .reset            (reset),
        .fire             (fire),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .weight_load_wr   (weight_load_wr),
        .weight_load_addr (weight_load_addr),
        .weight_load_data (weight_load_data),
        .feature_wr       (feature_wr),
        .feature_addr     (feature_addr),
        .feature_data     (feature_data),
        .rs_idle          (rs_idle),
        .beat             (beat),
        .sum_valid        (sum_valid),
        .sum_layer        (sum_layer),
        .layer_sum        (layer_sum),
        .done             (done)
    );

    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // reference dot product of one layer, element 2n in the low byte of line n
    function automatic int layer_dot(input int layer, input int nfv);
        int          sum;
        logic [15:0] word;
        logic [7:0]  w;
        sum = 0;
        for (int e = 0; e < nfv; e++) begin
            word = wmem[layer * LINES_PER_LAYER + e / 2];
            w    = (e % 2 == 1) ? word[15:8] : word[7:0];
            sum  = sum + int'(feat[e]) * int'(w);
        end
        return sum;
    endfunction

    function automatic int cycle_budget();
        int total;
        total = 16 + 20;
        for (int r = 0; r < NUM_CASES; r++) begin
            total = total + int'(CASES[r].beats) + 10 + LOAD_CYCLES;
        end
        return total;
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: no done from the DUT within %0d cycles", timeout_limit);
            $display("Verification failed");
            $fatal(1, "run did not finish in time");
        end
    end

    // beat and sum monitor, samples registered outputs at the edge
    always @(posedge clk) begin
        int line;
        int layer;
        if (reset && fire && rs_idle) begin
            beat_cnt  = 0;
            sum_cnt   = 0;
            done_seen = 1'b0;
        end
        if (reset && beat.valid) begin
            compare_value("beat count in range", 32'(beat_cnt < exp_beats), 32'd1);
            line  = beat_cnt % (exp_fv / 2);
            layer = beat_cnt / (exp_fv / 2);
            compare_value("beat.weight", 32'(beat.weight),
                          32'(wmem[layer * LINES_PER_LAYER + line]));
            compare_value("beat.fv_idx", 32'(beat.fv_idx), 32'(line * 2));
            compare_value("beat.ctl.sos", 32'(beat.ctl.sos), 32'(beat_cnt == 0));
            compare_value("beat.ctl.change", 32'(beat.ctl.change),
                          32'(line == exp_fv / 2 - 1));
            compare_value("beat.ctl.eos", 32'(beat.ctl.eos), 32'(beat_cnt == exp_beats - 1));
            beat_cnt = beat_cnt + 1;
        end
        if (reset) begin
            compare_value("done", 32'(done), 32'(sum_valid && (sum_cnt == exp_sums - 1)));
        end
        if (reset && sum_valid) begin
            compare_value("sum count in range", 32'(sum_cnt < exp_sums), 32'd1);
            compare_value("sum_layer", 32'(sum_layer), 32'(sum_cnt));
            compare_value("layer_sum", 32'(layer_sum), 32'(layer_dot(sum_cnt, exp_fv)));
            sum_cnt = sum_cnt + 1;
            if (done) begin
                done_seen = 1'b1;
            end
        end
    end

    task automatic run_case(input case_t c);
        logic [`WEIGHT_SRAM_BW-1:0] word;
        logic [`FV_SIZE-1:0]        fval;
        while (!rs_idle) @(posedge clk);
        exp_fv    = int'(c.num_fv);
        exp_beats = int'(c.beats);
        exp_sums  = int'(c.sums);
        for (int a = 0; a < SRAM_WORDS; a++) begin
            @(posedge clk);
            word    = c.all_ones ? '1 : `WEIGHT_SRAM_BW'($random(seed));
            wmem[a] = word;
            weight_load_wr   <= 1'b1;
            weight_load_addr <= `WEIGHT_SRAM_AW'(a);
            weight_load_data <= word;
        end
        for (int a = 0; a < `MAX_FV_NUM; a++) begin
            @(posedge clk);
            fval    = c.all_ones ? '1 : `FV_SIZE'($random(seed));
            feat[a] = fval;
            weight_load_wr <= 1'b0;
            feature_wr     <= 1'b1;
            feature_addr   <= `FV_IDX_W'(a);
            feature_data   <= fval;
        end
        @(posedge clk);
        feature_wr       <= 1'b0;
        num_weight_layer <= c.layers;
        num_fv           <= c.num_fv;
        fire             <= 1'b1;
        @(posedge clk);
        // fire held through the stream and the cycle after the last request
        // must not start a second stream
        if (c.busy_fire) begin
            repeat (int'(c.beats)) begin
                @(posedge clk);
                compare_value("rs_idle while busy", 32'(rs_idle), 32'd0);
            end
        end
        fire <= 1'b0;
        @(posedge clk);
        if (c.busy_fire) begin
            compare_value("rs_idle after last request", 32'(rs_idle), 32'd1);
        end
        while (!done_seen) @(posedge clk);
        repeat (3) @(posedge clk);
        compare_value("beat count", 32'(beat_cnt), 32'(c.beats));
        compare_value("sum count", 32'(sum_cnt), 32'(c.sums));
        compare_value("rs_idle after run", 32'(rs_idle), 32'd1);
    endtask

    initial begin
        reset            <= 1'b0;
        fire             <= 1'b0;
        num_weight_layer <= '0;
        num_fv           <= `FV_NUM_W'(2);
        weight_load_wr   <= 1'b0;
        weight_load_addr <= '0;
        weight_load_data <= '0;
        feature_wr       <= 1'b0;
        feature_addr     <= '0;
        feature_data     <= '0;
        timeout_limit = cycle_budget();
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        for (int r = 0; r < NUM_CASES; r++) begin
            run_case(CASES[r]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
